// File: dv/clocks_reset_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "clk_rst_cfg.svh"

module clocks_reset_tb;

	import clk_rst_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 5;
	localparam int SEED       = 88;
	localparam int HOLD_CYC   = 1 << `HOLD_BIT;
	localparam int HOLD_LIMIT = HOLD_CYC + 64;

	logic     clkin_b = 1'b0;
	logic     arst_n, reset, div_wr, div_rd, lcd_en, apu_reset, fero_q;
	tac_sel_t tac_sel;
	logic     nreset2, nreset_video, mcycle, timer_tick;
	logic     tick_512hz, tick_256hz, tick_128hz;
	phase_t   phase;
	logic [7:0] div_q;

	// Stimulus controls and bookkeeping.
	logic force_rst, wr_ok, apu_ok, fast_mode, timed_out;
	int   checks, errors, ticks_seen;

	// Reference model state.
	logic m_meta, m_sync, m_nrst2, m_nvid, m_ttap_q, m_ttick;
	logic m_ftap_q, m_step, m_t512, m_t256, m_t128;
	logic [2:0] m_cnt;
	div_t   m_div;
	phase_t m_phase;

	clocks_reset dut_i (.*);

	always #(CLK_PERIOD / 2) clkin_b = ~clkin_b;

	function automatic logic timer_tap(input tac_sel_t sel, input div_t d);
		timer_tap = 1'b0;
		case (sel)
			TAC_4096:   timer_tap = d[`TAP_4096];
			TAC_262144: timer_tap = d[`TAP_262144];
			TAC_65536:  timer_tap = d[`TAP_65536];
			TAC_16384:  timer_tap = d[`TAP_16384];
		endcase
	endfunction

	task automatic model_reset();
		{m_meta, m_sync} = 2'b11;
		{m_nrst2, m_nvid, m_ttap_q, m_ttick, m_ftap_q, m_step} = '0;
		{m_t512, m_t256, m_t128} = '0;
		m_cnt = '0;
		m_div = '0;
		m_phase = '0;
	endtask

	// One clock edge of the model. Every rule reads the state from before the edge.
	task automatic model_step();
		logic t_tap;
		logic f_tap;
		logic [2:0] nxt;
		t_tap = timer_tap(tac_sel, m_div);
		f_tap = fero_q ? m_div[`FAST_TAP] : m_div[`FRAME_TAP];
		m_ttick = m_ttap_q & ~t_tap;
		m_ttap_q = t_tap;
		nxt = m_cnt + 3'd1;
		if (apu_reset) begin
			m_cnt = 3'd0;
			{m_t512, m_t256, m_t128} = 3'b000;
		end else begin
			m_t512 = m_step;
			m_t256 = m_step & (nxt % 2 == 0);
			m_t128 = m_step & (nxt % 4 == 0);
			if (m_step) m_cnt = nxt;
		end
		m_step = m_ftap_q & ~f_tap;
		m_ftap_q = f_tap;
		m_phase = m_nrst2 ? m_phase + 2'd1 : 2'd0;
		m_nvid = m_nrst2 & lcd_en;
		if (m_sync) m_nrst2 = 1'b0;
		else if (m_div[`HOLD_BIT]) m_nrst2 = 1'b1; // Latches until the next reset.
		m_div = (m_sync || div_wr) ? '0 : m_div + div_t'(1);
		m_sync = m_meta;
		m_meta = reset;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic check_div(input string name, input div_t got, input div_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
		end
	endtask

	task automatic check_phase(input string name, input phase_t got, input phase_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
		end
	endtask

	// Outputs are compared at the falling edge, half a period after they settle.
	task automatic cycle();
		logic [1:0] sel;
		@(posedge clkin_b);
		model_step();
		sel = 2'($urandom);
		reset  <= force_rst;
		div_wr <= wr_ok && ($urandom % 64 == 0);
		div_rd <= ($urandom % 4 == 0);
		if ($urandom % 200 == 0) tac_sel <= tac_sel_t'(sel);
		if ($urandom % 300 == 0) lcd_en <= ~lcd_en;
		if (apu_reset) apu_reset <= ($urandom % 16 != 0);
		else apu_reset <= apu_ok && ($urandom % 400 == 0);
		fero_q <= fast_mode;
		@(negedge clkin_b);
		check_bit("nreset2", nreset2, m_nrst2);
		check_bit("nreset_video", nreset_video, m_nvid);
		check_phase("phase", phase, m_phase);
		check_bit("mcycle", mcycle, m_phase == 2'd3);
		check_div("div_q", div_t'(div_q), div_rd ? (m_div >> (`DIV_WIDTH - 8)) : '0);
		check_bit("timer_tick", timer_tick, m_ttick);
		check_bit("tick_512hz", tick_512hz, m_t512);
		check_bit("tick_256hz", tick_256hz, m_t256);
		check_bit("tick_128hz", tick_128hz, m_t128);
		if (tick_512hz) ticks_seen++;
	endtask

	task automatic wait_release(output int n);
		logic rose;
		n = 0;
		rose = 1'b0;
		while (!rose && n < HOLD_LIMIT) begin
			cycle();
			n++;
			rose = nreset2;
		end
		if (!rose) begin
			$display("nreset2 stayed low for %0d cycles after reset fell", n);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_reset_test();
		int n;
		int e0;
		e0 = errors;
		wait_release(n); // Power-up hold.
		for (int i = 0; i < 3 && !timed_out; i++) begin
			force_rst = 1'b1;
			repeat (4 + $urandom % 5) cycle();
			force_rst = 1'b0;
			wait_release(n);
			// The first counted cycle is the edge that drops reset.
			if (!timed_out && (n - 1 < HOLD_CYC || n - 1 > HOLD_CYC + 4)) begin
				errors++;
				$display("nreset2 rose %0d cycles after reset fell, outside the hold window",
					n - 1);
			end
			repeat (100) cycle();
		end
		$display("reset_hold: 3 reset pulses, %0d errors", errors - e0);
	endtask

	task automatic run_test(input string name, input logic wr, input logic apu,
		input logic fast, input int len);
		int e0;
		e0 = errors;
		ticks_seen = 0;
		{wr_ok, apu_ok, fast_mode} = {wr, apu, fast};
		repeat (len) cycle();
		$display("%s: %0d cycles, %0d frame ticks, %0d errors", name, len, ticks_seen,
			errors - e0);
	endtask

	initial begin
		void'($urandom(SEED));
		{arst_n, reset, div_wr, div_rd, apu_reset, fero_q} = '0;
		lcd_en = 1'b1;
		tac_sel = TAC_4096;
		{force_rst, wr_ok, apu_ok, fast_mode, timed_out} = '0;
		checks = 0;
		errors = 0;
		model_reset();
		repeat (RST_CYCLES) @(posedge clkin_b);
		arst_n <= 1'b1;
		run_reset_test();
		if (!timed_out) begin
			run_test("divider_timer", 1'b1, 1'b0, 1'b0, 4000);
			run_test("frame_normal", 1'b0, 1'b0, 1'b0, 70000); // Eight steps of bit 12.
			run_test("frame_fast", 1'b1, 1'b1, 1'b1, 6000);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/clk_rst_pkg.sv
hdl/reset_seq.sv
hdl/phase_gen.sv
hdl/div_counter.sv
hdl/frame_seq.sv
hdl/clocks_reset.sv
dv/clocks_reset_tb.sv

// File: hdl/clk_rst_cfg.svh
`ifndef CLK_RST_CFG_SVH
`define CLK_RST_CFG_SVH

// System divider width, counted in 4 MHz clocks.
`define DIV_WIDTH 16

// First rise of this bit ends the oscillator settle hold (about 256 us).
`define HOLD_BIT 10

// APU frame sequencer taps. Bit 12 falls at 512 Hz.
`define FRAME_TAP 12
`define FAST_TAP 4

// Timer taps, one per timer select value.
`define TAP_4096 9
`define TAP_262144 3
`define TAP_65536 5
`define TAP_16384 7

`endif

// File: hdl/clk_rst_pkg.sv
`default_nettype none

`include "clk_rst_cfg.svh"

package clk_rst_pkg;

	// Full divider word.
	typedef logic [`DIV_WIDTH-1:0] div_t;

	// Position inside the machine cycle. Phase 3 is the last clock.
	typedef logic [1:0] phase_t;

	// Timer input clock select. The encoding follows the CPU register field.
	typedef enum logic [1:0] {
		TAC_4096   = 2'b00,
		TAC_262144 = 2'b01,
		TAC_65536  = 2'b10,
		TAC_16384  = 2'b11
	} tac_sel_t;

endpackage

`default_nettype wire

// File: hdl/clocks_reset.sv
`timescale 1ns/10ps
`default_nettype none

module clocks_reset (
	input  logic                  clkin_b,
	input  logic                  arst_n,
	input  logic                  reset,
	input  logic                  div_wr,
	input  logic                  div_rd,
	input  clk_rst_pkg::tac_sel_t tac_sel,
	input  logic                  lcd_en,
	input  logic                  apu_reset,
	input  logic                  fero_q,
	output logic                  nreset2,
	output logic                  nreset_video,
	output clk_rst_pkg::phase_t   phase,
	output logic                  mcycle,
	output logic [7:0]            div_q,
	output logic                  timer_tick,
	output logic                  tick_512hz,
	output logic                  tick_256hz,
	output logic                  tick_128hz
);

	import clk_rst_pkg::*;

	logic div_clr;
	div_t div_val;

	reset_seq reset_seq_i (
		.clkin_b      (clkin_b),
		.arst_n       (arst_n),
		.reset        (reset),
		.div_val      (div_val),
		.lcd_en       (lcd_en),
		.div_clr      (div_clr),
		.nreset2      (nreset2),
		.nreset_video (nreset_video)
	);

	phase_gen phase_gen_i (
		.clkin_b (clkin_b),
		.arst_n  (arst_n),
		.nreset2 (nreset2),
		.phase   (phase),
		.mcycle  (mcycle)
	);

	// The divider also times the power-up hold in reset_seq.
	div_counter div_counter_i (
		.clkin_b    (clkin_b),
		.arst_n     (arst_n),
		.div_clr    (div_clr),
		.div_wr     (div_wr),
		.div_rd     (div_rd),
		.tac_sel    (tac_sel),
		.div_val    (div_val),
		.div_q      (div_q),
		.timer_tick (timer_tick)
	);

	frame_seq frame_seq_i (
		.clkin_b    (clkin_b),
		.arst_n     (arst_n),
		.div_val    (div_val),
		.apu_reset  (apu_reset),
		.fero_q     (fero_q),
		.tick_512hz (tick_512hz),
		.tick_256hz (tick_256hz),
		.tick_128hz (tick_128hz)
	);

endmodule

`default_nettype wire

// File: hdl/div_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "clk_rst_cfg.svh"

module div_counter (
	input  logic                  clkin_b,
	input  logic                  arst_n,
	input  logic                  div_clr,
	input  logic                  div_wr,
	input  logic                  div_rd,
	input  clk_rst_pkg::tac_sel_t tac_sel,
	output clk_rst_pkg::div_t     div_val,
	output logic [7:0]            div_q,
	output logic                  timer_tick
);

	import clk_rst_pkg::*;

	logic tap;
	logic tap_q;

	// Any CPU write clears the whole divider, not just the visible byte.
	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			div_val <= '0;
		end else if (div_clr || div_wr) begin
			div_val <= '0;
		end else begin
			div_val <= div_val + 1'b1;
		end
	end

	// Only the upper byte is visible to the CPU.
	assign div_q = div_rd ? div_val[`DIV_WIDTH-1 -: 8] : 8'h00;

	always_comb begin
		case (tac_sel)
			TAC_4096:   tap = div_val[`TAP_4096];
			TAC_262144: tap = div_val[`TAP_262144];
			TAC_65536:  tap = div_val[`TAP_65536];
			TAC_16384:  tap = div_val[`TAP_16384];
			default:    tap = 1'b0;
		endcase
	end

	// Falling edge of the selected tap. The old value is taken from the
	// previous selection, so switching taps can also fire a tick.
	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			tap_q      <= 1'b0;
			timer_tick <= 1'b0;
		end else begin
			tap_q      <= tap;
			timer_tick <= tap_q & ~tap;
		end
	end

	a_div_wr_clears: assert property (
		@(posedge clkin_b) disable iff (!arst_n)
		div_wr |=> (div_val == '0)
	);

endmodule

`default_nettype wire

// File: hdl/frame_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "clk_rst_cfg.svh"

module frame_seq (
	input  logic              clkin_b,
	input  logic              arst_n,
	input  clk_rst_pkg::div_t div_val,
	input  logic              apu_reset,
	input  logic              fero_q,
	output logic              tick_512hz,
	output logic              tick_256hz,
	output logic              tick_128hz
);

	logic       tap;
	logic       tap_q;
	logic       step;
	logic [2:0] step_cnt;
	logic [2:0] step_nxt;

	// Test mode runs the frame sequencer from a much faster divider bit.
	assign tap = fero_q ? div_val[`FAST_TAP] : div_val[`FRAME_TAP];

	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			tap_q <= 1'b0;
			step  <= 1'b0;
		end else begin
			tap_q <= tap;
			step  <= tap_q & ~tap; // One step per falling edge.
		end
	end

	assign step_nxt = step_cnt + 3'd1;

	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			step_cnt   <= 3'd0;
			tick_512hz <= 1'b0;
			tick_256hz <= 1'b0;
			tick_128hz <= 1'b0;
		end else if (apu_reset) begin
			step_cnt   <= 3'd0; // Sequence restarts from step zero.
			tick_512hz <= 1'b0;
			tick_256hz <= 1'b0;
			tick_128hz <= 1'b0;
		end else begin
			tick_512hz <= step;
			tick_256hz <= step & ~step_nxt[0];
			tick_128hz <= step & (step_nxt[1:0] == 2'd0);
			if (step) begin
				step_cnt <= step_nxt;
			end
		end
	end

	// Slower ticks always coincide with the faster ones.
	a_tick_nesting: assert property (
		@(posedge clkin_b) disable iff (!arst_n)
		(!tick_128hz || tick_256hz) && (!tick_256hz || tick_512hz)
	);

endmodule

`default_nettype wire

// File: hdl/phase_gen.sv
`timescale 1ns/10ps
`default_nettype none

module phase_gen (
	input  logic                clkin_b,
	input  logic                arst_n,
	input  logic                nreset2,
	output clk_rst_pkg::phase_t phase,
	output logic                mcycle
);

	// Four system clocks make one machine cycle.
	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			phase <= 2'd0;
		end else if (!nreset2) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1; // Wraps from 3 back to 0.
		end
	end

	// Strobe on the last clock of the machine cycle.
	assign mcycle = (phase == 2'd3);

	// The first cycle after reset release always starts at phase 0.
	a_phase_zero_in_reset: assert property (
		@(posedge clkin_b) disable iff (!arst_n)
		!nreset2 |=> (phase == 2'd0)
	);

endmodule

`default_nettype wire

// File: hdl/reset_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "clk_rst_cfg.svh"

module reset_seq (
	input  logic              clkin_b,
	input  logic              arst_n,
	input  logic              reset,
	input  clk_rst_pkg::div_t div_val,
	input  logic              lcd_en,
	output logic              div_clr,
	output logic              nreset2,
	output logic              nreset_video
);

	logic rst_meta;
	logic rst_sync;

	// Two flop synchronizer for the external reset pin.
	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			rst_meta <= 1'b1;
			rst_sync <= 1'b1;
		end else begin
			rst_meta <= reset;
			rst_sync <= rst_meta;
		end
	end

	assign div_clr = rst_sync; // The divider restarts from zero when reset is released.

	// The system stays in reset until the divider has counted out the
	// oscillator settle time, then latches high until the next reset.
	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			nreset2 <= 1'b0;
		end else if (rst_sync) begin
			nreset2 <= 1'b0;
		end else if (div_val[`HOLD_BIT]) begin
			nreset2 <= 1'b1;
		end
	end

	always_ff @(posedge clkin_b or negedge arst_n) begin
		if (!arst_n) begin
			nreset_video <= 1'b0;
		end else begin
			nreset_video <= nreset2 & lcd_en; // Video runs only with the LCD on.
		end
	end

	// A synchronized reset keeps the system in reset on the next cycle.
	a_no_release_in_reset: assert property (
		@(posedge clkin_b) disable iff (!arst_n)
		rst_sync |=> !nreset2
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f filelist.f --top-module clocks_reset_tb \
	-o clocks_reset_sim \
	&& ./obj_dir/clocks_reset_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
exit 0
